/* operator_top.f */
src/fm_pkg.sv
src/operator_regs.sv
src/param_arbiter.sv
src/slot_sequencer.sv
src/wave_tables.sv
src/phase_generator.sv
src/operator_top.sv
test/operator_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the operator bank testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module operator_tb -f operator_top.f -o operator_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/operator_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only when the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

/* test/operator_patterns.txt */
# N test number | W slot field data(hex), field 0 increment 1 waveform 2 attenuation 3 restart
# T sample tick | E expected 13-bit hex samples of slots 0 to 7, in output order
N 1
E 000c 000c 000c 000c 000c 000c 000c 000c
T
N 2
W 0 0 20000
W 1 0 20000
W 2 0 20000
W 3 0 20000
W 4 0 10000
W 5 0 20000
W 6 0 20000
W 7 0 20000
W 1 1 1
W 2 1 2
W 3 1 3
W 6 1 2
W 5 2 20
W 6 2 10
W 7 2 40
E 0ff4 0ff4 0ff4 0000 0b50 07fa 0b48 03fd
T
N 3
E 1ff3 0000 000c 000c 0ff4 1ff9 0008 1ffc
T
W 0 0 20000
W 5 2 20
W 3 1 3
N 4
W 7 3 0
E 100b 0000 0ff4 0000 0b40 1805 0b48 0003
T
N 5
E 000c 000c 000c 000c 1ff3 0006 0008 03fd
T

/* test/operator_tb.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the FM operator bank, replays test/operator_patterns.txt
// host writes and sample ticks are driven, every output is compared in slot order
// ~~~~~~~~~~~~~~~~~~~~
module operator_tb;

    localparam int TIMEOUT_CYCLES = 200;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           wr_en;
    fm_pkg::slot_t                  wr_slot;
    logic [fm_pkg::FIELD_WIDTH-1:0] wr_field;
    fm_pkg::phase_inc_t             wr_data;
    logic                           sample_tick;
    logic                           wr_busy;
    logic                           out_valid;
    fm_pkg::slot_t                  out_slot;
    fm_pkg::op_out_t                out_sample;

    fm_pkg::slot_t   exp_slots [$];       // expected outputs in arrival order
    fm_pkg::op_out_t exp_samples [$];
    int              err_count   = 0;
    int              check_count = 0;
    int              test_errs   = 0;     // errors of the running test only
    int              test_id     = 0;     // stays 0 until the first N line
    bit              aborted     = 1'b0;  // set by a timeout or a bad pattern file
    logic [31:0]     rnd         = 32'h4b06bedc;

    operator_top u_operator_top (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_slot     (wr_slot),
        .wr_field    (wr_field),
        .wr_data     (wr_data),
        .sample_tick (sample_tick),
        .wr_busy     (wr_busy),
        .out_valid   (out_valid),
        .out_slot    (out_slot),
        .out_sample  (out_sample)
    );

    always #4 clk = ~clk;  // 8 ns period

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~ compare tasks
    task automatic check_slot(input fm_pkg::slot_t got, input fm_pkg::slot_t want);
        check_count++;
        if (got !== want) begin
            $display("FAIL out_slot got 0x%h expected 0x%h", got, want);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_sample(input fm_pkg::op_out_t got, input fm_pkg::op_out_t want);
        check_count++;
        if (got !== want) begin
            $display("FAIL out_sample got 0x%h expected 0x%h", got, want);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_busy(input logic got, input logic want);
        check_count++;
        if (got !== want) begin
            $display("FAIL wr_busy got 0x%h expected 0x%h", got, want);
            err_count++;
            test_errs++;
        end
    endtask

    // outputs settle after the rising edge, so they are taken at the falling edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_slots.size() == 0) begin
                $display("slot %0d produced an output with no expected value queued", out_slot);
                err_count++;
                test_errs++;
            end else begin
                check_slot(out_slot, exp_slots.pop_front());
                check_sample(out_sample, exp_samples.pop_front());
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~ drivers
    task automatic idle_gap();
        rnd = lcg_step(rnd);
        repeat (rnd[17:16]) begin  // zero to three idle cycles
            @(posedge clk);
        end
    endtask

    task automatic wait_host_idle();
        int n;
        n = 0;
        while (wr_busy && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (wr_busy) begin
            $display("wr_busy stayed high for %0d cycles", TIMEOUT_CYCLES);
            aborted = 1'b1;
        end
    endtask

    task automatic drive_write(input fm_pkg::slot_t slot,
                               input logic [fm_pkg::FIELD_WIDTH-1:0] field,
                               input fm_pkg::phase_inc_t data);
        @(posedge clk);
        #1;
        wait_host_idle();  // a second strobe while busy is not allowed
        if (!aborted) begin
            wr_en    = 1'b1;
            wr_slot  = slot;
            wr_field = field;
            wr_data  = data;
            @(posedge clk);
            #1;
            wr_en = 1'b0;
            check_busy(wr_busy, 1'b1);  // the write just strobed is now pending
        end
    endtask

    task automatic drive_tick();
        @(posedge clk);
        #1;
        sample_tick = 1'b1;
        @(posedge clk);
        #1;
        sample_tick = 1'b0;
    endtask

    // a test ends once every queued output has come out
    task automatic finish_test();
        int n;
        n = 0;
        while (exp_slots.size() != 0 && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_slots.size() != 0) begin
            $display("test %0d still waits for %0d outputs", test_id, exp_slots.size());
            aborted = 1'b1;
        end else if (test_id != 0) begin
            if (test_errs == 0) begin
                $display("test %0d: ok", test_id);
            end else begin
                $display("test %0d: %0d errors", test_id, test_errs);
            end
        end
        test_errs = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~ pattern replay
    initial begin
        int              fd;
        int              code;
        int              slot_num;
        int              field_num;
        int              next_id;
        logic [31:0]     data;
        string           line;
        fm_pkg::op_out_t frame [fm_pkg::NUM_SLOTS];

        rst         = 1'b1;
        wr_en       = 1'b0;
        wr_slot     = '0;
        wr_field    = '0;
        wr_data     = '0;
        sample_tick = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("test/operator_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open test/operator_patterns.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0) begin
                case (line[0])
                    "N": begin
                        finish_test();  // closes the previous test
                        code    = $sscanf(line, "N %d", next_id);
                        test_id = next_id;
                    end
                    "W": begin
                        code = $sscanf(line, "W %d %d %h", slot_num, field_num, data);
                        if (code != 3) begin
                            $display("a write line in the pattern file could not be read");
                            aborted = 1'b1;
                        end else begin
                            idle_gap();
                            drive_write(fm_pkg::slot_t'(slot_num),
                                        fm_pkg::FIELD_WIDTH'(field_num),
                                        fm_pkg::phase_inc_t'(data));
                        end
                    end
                    "T": begin
                        idle_gap();
                        drive_tick();
                    end
                    "E": begin
                        code = $sscanf(line, "E %h %h %h %h %h %h %h %h", frame[0], frame[1],
                                       frame[2], frame[3], frame[4], frame[5], frame[6], frame[7]);
                        if (code != fm_pkg::NUM_SLOTS) begin
                            $display("an expected line in the pattern file could not be read");
                            aborted = 1'b1;
                        end
                        for (int i = 0; i < fm_pkg::NUM_SLOTS; i++) begin
                            exp_slots.push_back(fm_pkg::slot_t'(i));  // frames leave in order
                            exp_samples.push_back(frame[i]);
                        end
                    end
                    default: ;  // comment or blank line
                endcase
            end
        end
        if (!aborted) begin
            finish_test();
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0 && check_count > 0 && !aborted) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* src/operator_top.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// top of the FM operator bank with host write port, sample tick and sample output
// ~~~~~~~~~~~~~~~~~~~~
module operator_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_en,
    input  fm_pkg::slot_t                  wr_slot,
    input  logic [fm_pkg::FIELD_WIDTH-1:0] wr_field,
    input  fm_pkg::phase_inc_t             wr_data,
    input  logic                           sample_tick,
    output logic                           wr_busy,
    output logic                           out_valid,
    output fm_pkg::slot_t                  out_slot,
    output fm_pkg::op_out_t                out_sample
);
    logic                           seq_req;
    logic                           seq_grant;
    fm_pkg::slot_t                  seq_slot;
    logic                           mem_we;
    logic                           mem_rd;
    fm_pkg::slot_t                  mem_slot;
    logic [fm_pkg::FIELD_WIDTH-1:0] mem_field;
    fm_pkg::phase_inc_t             mem_wdata;
    logic                           param_valid;
    fm_pkg::slot_t                  param_slot;
    fm_pkg::phase_inc_t             phase_inc;
    fm_pkg::waveform_t              ws;
    fm_pkg::atten_t                 atten;
    logic                           restart;

    param_arbiter u_param_arbiter (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_slot   (wr_slot),
        .wr_field  (wr_field),
        .wr_data   (wr_data),
        .seq_req   (seq_req),
        .seq_slot  (seq_slot),
        .wr_busy   (wr_busy),
        .seq_grant (seq_grant),
        .mem_we    (mem_we),
        .mem_rd    (mem_rd),
        .mem_slot  (mem_slot),
        .mem_field (mem_field),
        .mem_wdata (mem_wdata)
    );

    operator_regs u_operator_regs (
        .clk       (clk),
        .rst       (rst),
        .mem_we    (mem_we),
        .mem_rd    (mem_rd),
        .mem_slot  (mem_slot),
        .mem_field (mem_field),
        .mem_wdata (mem_wdata),
        .phase_inc (phase_inc),
        .ws        (ws),
        .atten     (atten),
        .restart   (restart)
    );

    slot_sequencer u_slot_sequencer (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .seq_grant   (seq_grant),
        .seq_req     (seq_req),
        .seq_slot    (seq_slot),
        .param_valid (param_valid),
        .param_slot  (param_slot)
    );

    phase_generator u_phase_generator (
        .clk         (clk),
        .rst         (rst),
        .param_valid (param_valid),
        .param_slot  (param_slot),
        .phase_inc   (phase_inc),
        .ws          (ws),
        .atten       (atten),
        .restart     (restart),
        .out_valid   (out_valid),
        .out_slot    (out_slot),
        .out_sample  (out_sample)
    );

endmodule

/* src/phase_generator.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// per-slot phase accumulator, waveform shaping and log to linear conversion
// one slot may enter per cycle and each leaves five cycles after param_valid
// ~~~~~~~~~~~~~~~~~~~~
module phase_generator (
    input  logic               clk,
    input  logic               rst,
    input  logic               param_valid,
    input  fm_pkg::slot_t      param_slot,
    input  fm_pkg::phase_inc_t phase_inc,
    input  fm_pkg::waveform_t  ws,
    input  fm_pkg::atten_t     atten,
    input  logic               restart,
    output logic               out_valid,
    output fm_pkg::slot_t      out_slot,
    output fm_pkg::op_out_t    out_sample
);
    logic [fm_pkg::PIPE_DEPTH-1:0] valid_sr;              // bit 0 is stage p2
    fm_pkg::slot_t                 slot_sr [fm_pkg::PIPE_DEPTH];
    fm_pkg::phase_inc_t            acc_mem [fm_pkg::NUM_SLOTS];

    fm_pkg::phase_inc_t acc_p2;   // accumulator read in p1
    fm_pkg::phase_inc_t inc_p2;
    fm_pkg::waveform_t  ws_p2;
    fm_pkg::atten_t     atten_p2;
    logic               restart_p2;
    fm_pkg::phase_inc_t acc_new_p2;
    fm_pkg::phase_t     phase_p2;
    logic [fm_pkg::TABLE_INDEX_WIDTH-1:0] index_p2;
    logic               mute_p2;
    logic               neg_p2;

    logic [fm_pkg::TABLE_INDEX_WIDTH-1:0] index_p3;
    fm_pkg::atten_t     atten_p3;
    fm_pkg::atten_t     atten_p4;
    logic               mute_p3;
    logic               mute_p4;
    logic               neg_p3;
    logic               neg_p4;
    logic               neg_p5;

    fm_pkg::log_t                      log_sin_p4;
    logic [fm_pkg::LEVEL_WIDTH-1:0]    pre_p4;
    logic [fm_pkg::LEVEL_WIDTH:0]      sum_p4;    // one spare bit before saturation
    logic [fm_pkg::LEVEL_WIDTH-1:0]    level_p4;
    logic [fm_pkg::LEVEL_WIDTH-1:0]    level_p5;
    logic [fm_pkg::EXP_WIDTH-1:0]      exp_p5;
    logic [fm_pkg::OUT_WIDTH-1:0]      mag_p5;

    // ~~~~~~~~~~~~~~~~~~~~ valid and slot tags
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
            for (int i = 0; i < fm_pkg::PIPE_DEPTH; i++) begin
                slot_sr[i] <= '0;
            end
        end else begin
            valid_sr   <= {valid_sr[fm_pkg::PIPE_DEPTH-2:0], param_valid};
            slot_sr[0] <= param_slot;
            for (int i = 1; i < fm_pkg::PIPE_DEPTH; i++) begin
                slot_sr[i] <= slot_sr[i-1];
            end
        end
    end

    assign out_valid = valid_sr[fm_pkg::PIPE_DEPTH-1];
    assign out_slot  = slot_sr[fm_pkg::PIPE_DEPTH-1];

    // ~~~~~~~~~~~~~~~~~~~~ p1 and p2 accumulate
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fm_pkg::NUM_SLOTS; i++) begin
                acc_mem[i] <= '0;
            end
            acc_p2 <= '0;
        end else begin
            acc_p2 <= acc_mem[param_slot];             // read port
            if (valid_sr[0]) begin
                acc_mem[slot_sr[0]] <= acc_new_p2;     // write port, never the slot read now
            end
        end
    end

    always_ff @(posedge clk) begin
        inc_p2     <= phase_inc;
        ws_p2      <= ws;
        atten_p2   <= atten;
        restart_p2 <= restart;
    end

    always_comb begin
        acc_new_p2 = restart_p2 ? '0 : acc_p2 + inc_p2;  // wraps modulo one full cycle
        phase_p2   = acc_new_p2[fm_pkg::PHASE_ACC_WIDTH-1 -: fm_pkg::PHASE_WIDTH];
        index_p2   = phase_p2[8] ? ~phase_p2[7:0] : phase_p2[7:0];  // second quarter mirrors
        mute_p2    = (ws_p2 == 2'd1 && phase_p2[9]) || (ws_p2 == 2'd3 && phase_p2[8]);
        neg_p2     = (ws_p2 == 2'd0) && phase_p2[9];  // only the full sine swings negative
    end

    // ~~~~~~~~~~~~~~~~~~~~ p3 to p5 tables, level and sign
    always_ff @(posedge clk) begin
        index_p3 <= index_p2;
        atten_p3 <= atten_p2;
        mute_p3  <= mute_p2;
        neg_p3   <= neg_p2;
        atten_p4 <= atten_p3;
        mute_p4  <= mute_p3;
        neg_p4   <= neg_p3;
        level_p5 <= level_p4;
        neg_p5   <= neg_p4;
    end

    wave_tables u_wave_tables (
        .clk       (clk),
        .sin_index (index_p3),
        .exp_index (~level_p4[7:0]),
        .log_sin   (log_sin_p4),
        .exp_val   (exp_p5)
    );

    always_comb begin
        pre_p4   = mute_p4 ? fm_pkg::MUTE_LEVEL : {1'b0, log_sin_p4};
        sum_p4   = {1'b0, pre_p4} + {2'b00, atten_p4, 3'b000};  // attenuation in 1/8 steps
        level_p4 = (sum_p4 > {1'b0, fm_pkg::LEVEL_MAX}) ? fm_pkg::LEVEL_MAX
                                                         : sum_p4[fm_pkg::LEVEL_WIDTH-1:0];
        mag_p5   = {1'b0, 1'b1, exp_p5, 1'b0} >> level_p5[12:8];  // whole octaves shift right
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_sample <= '0;
        end else begin
            out_sample <= fm_pkg::op_out_t'(neg_p5 ? ~mag_p5 : mag_p5);  // one's complement
        end
    end

endmodule

/* src/wave_tables.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// quarter-wave log-sine ROM and exponent ROM, both with a registered output
// contents come from the closed formulas when the design starts up
// ~~~~~~~~~~~~~~~~~~~~
module wave_tables (
    input  logic                                 clk,
    input  logic [fm_pkg::TABLE_INDEX_WIDTH-1:0] sin_index,
    input  logic [fm_pkg::TABLE_INDEX_WIDTH-1:0] exp_index,
    output fm_pkg::log_t                         log_sin,
    output logic [fm_pkg::EXP_WIDTH-1:0]         exp_val
);
    fm_pkg::log_t               sin_rom [fm_pkg::TABLE_SIZE];
    logic [fm_pkg::EXP_WIDTH-1:0] exp_rom [fm_pkg::TABLE_SIZE];

    // minus log2 of the sine at the middle of step i, in 1/256 units
    function automatic fm_pkg::log_t log_sin_entry(input int i);
        real angle;
        real value;
        angle = (real'(i) + 0.5) / real'(fm_pkg::TABLE_SIZE) * fm_pkg::PI / 2.0;
        value = -$ln($sin(angle)) / $ln(2.0) * 256.0;
        return fm_pkg::log_t'($rtoi(value + 0.5));
    endfunction

    // fractional part of 2 to the i/256, scaled to the 10 bit word
    function automatic logic [fm_pkg::EXP_WIDTH-1:0] exp_entry(input int i);
        real value;
        value = ($pow(2.0, real'(i) / real'(fm_pkg::TABLE_SIZE)) - 1.0) * 1024.0;
        return fm_pkg::EXP_WIDTH'($rtoi(value + 0.5));
    endfunction

    initial begin
        for (int i = 0; i < fm_pkg::TABLE_SIZE; i++) begin
            sin_rom[i] = log_sin_entry(i);
            exp_rom[i] = exp_entry(i);
        end
    end

    always_ff @(posedge clk) begin
        log_sin <= sin_rom[sin_index];  // one cycle of ROM latency each
        exp_val <= exp_rom[exp_index];
    end

endmodule

/* src/slot_sequencer.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// walks slots 0 to 7 once per sample tick through the arbiter
// param_valid marks the cycle in which the memory read data is present
// ~~~~~~~~~~~~~~~~~~~~
module slot_sequencer (
    input  logic          clk,
    input  logic          rst,
    input  logic          sample_tick,
    input  logic          seq_grant,
    output logic          seq_req,
    output fm_pkg::slot_t seq_slot,
    output logic          param_valid,
    output fm_pkg::slot_t param_slot
);
    fm_pkg::seq_state_t state;
    fm_pkg::slot_t      slot_cnt;  // slot being requested in WALK

    assign seq_req  = (state == fm_pkg::WALK);
    assign seq_slot = slot_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= fm_pkg::IDLE;
            slot_cnt    <= '0;
            param_valid <= 1'b0;
            param_slot  <= '0;
        end else begin
            param_valid <= seq_grant;  // read data follows the grant by one cycle
            if (seq_grant) begin
                param_slot <= slot_cnt;
            end
            case (state)
                fm_pkg::IDLE: begin
                    if (sample_tick) begin
                        state    <= fm_pkg::WALK;
                        slot_cnt <= '0;
                    end
                end
                default: begin  // ticks are ignored while a frame is walked
                    if (seq_grant) begin
                        if (slot_cnt == fm_pkg::slot_t'(fm_pkg::NUM_SLOTS - 1)) begin
                            state <= fm_pkg::IDLE;
                        end
                        slot_cnt <= slot_cnt + 1'b1;  // wraps back to 0 after the last slot
                    end
                end
            endcase
        end
    end

    // a grant only ever answers a request that this sequencer has raised
    a_grant_requested: assert property (@(posedge clk) disable iff (rst)
        seq_grant |-> seq_req);

endmodule

/* src/param_arbiter.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// shares the parameter memory port between the host and the slot sequencer
// a host write is held one cycle and always wins over a sequencer read
// ~~~~~~~~~~~~~~~~~~~~
module param_arbiter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_en,
    input  fm_pkg::slot_t                  wr_slot,
    input  logic [fm_pkg::FIELD_WIDTH-1:0] wr_field,
    input  fm_pkg::phase_inc_t             wr_data,
    input  logic                           seq_req,
    input  fm_pkg::slot_t                  seq_slot,
    output logic                           wr_busy,
    output logic                           seq_grant,
    output logic                           mem_we,
    output logic                           mem_rd,
    output fm_pkg::slot_t                  mem_slot,
    output logic [fm_pkg::FIELD_WIDTH-1:0] mem_field,
    output fm_pkg::phase_inc_t             mem_wdata
);
    logic                           pend_valid;  // one host write waiting for the port
    fm_pkg::slot_t                  pend_slot;
    logic [fm_pkg::FIELD_WIDTH-1:0] pend_field;
    fm_pkg::phase_inc_t             pend_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= wr_en;  // host priority means it is served in the next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pend_slot  <= wr_slot;
            pend_field <= wr_field;
            pend_data  <= wr_data;
        end
    end

    assign wr_busy   = pend_valid;
    assign mem_we    = pend_valid;
    assign mem_rd    = seq_req && !pend_valid;  // a refused read is asked again next cycle
    assign seq_grant = mem_rd;
    assign mem_slot  = pend_valid ? pend_slot : seq_slot;
    assign mem_field = pend_field;
    assign mem_wdata = pend_data;

    // the single port never sees a write and a read in the same cycle
    a_port_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_we && mem_rd));

    // the host only strobes while no earlier write is pending
    a_host_write: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !wr_busy);

endmodule

/* src/operator_regs.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~
// per-slot parameter memory with one port shared by host writes and sequencer reads
// a write updates one field, a read returns the whole word one cycle later
// ~~~~~~~~~~~~~~~~~~~~
module operator_regs (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           mem_we,
    input  logic                           mem_rd,
    input  fm_pkg::slot_t                  mem_slot,
    input  logic [fm_pkg::FIELD_WIDTH-1:0] mem_field,
    input  fm_pkg::phase_inc_t             mem_wdata,
    output fm_pkg::phase_inc_t             phase_inc,
    output fm_pkg::waveform_t              ws,
    output fm_pkg::atten_t                 atten,
    output logic                           restart
);
    fm_pkg::phase_inc_t inc_mem     [fm_pkg::NUM_SLOTS];
    fm_pkg::waveform_t  ws_mem      [fm_pkg::NUM_SLOTS];
    fm_pkg::atten_t     atten_mem   [fm_pkg::NUM_SLOTS];
    logic               restart_mem [fm_pkg::NUM_SLOTS];  // pending phase reset per slot

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fm_pkg::NUM_SLOTS; i++) begin
                inc_mem[i]     <= '0;  // silent slots at phase 0 after reset
                ws_mem[i]      <= '0;
                atten_mem[i]   <= '0;
                restart_mem[i] <= 1'b0;
            end
            phase_inc <= '0;
            ws        <= '0;
            atten     <= '0;
            restart   <= 1'b0;
        end else begin
            if (mem_we) begin
                case (mem_field)  // only the addressed field changes
                    fm_pkg::FIELD_PHASE_INC: inc_mem[mem_slot] <= mem_wdata;
                    fm_pkg::FIELD_WS: ws_mem[mem_slot] <= mem_wdata[fm_pkg::WS_WIDTH-1:0];
                    fm_pkg::FIELD_ATTEN: atten_mem[mem_slot] <= mem_wdata[fm_pkg::ATTEN_WIDTH-1:0];
                    default: restart_mem[mem_slot] <= 1'b1;  // data is ignored for a restart
                endcase
            end
            if (mem_rd) begin
                phase_inc <= inc_mem[mem_slot];
                ws        <= ws_mem[mem_slot];
                atten     <= atten_mem[mem_slot];
                restart   <= restart_mem[mem_slot];
                restart_mem[mem_slot] <= 1'b0;  // the read consumes the request
            end
        end
    end

endmodule

/* src/fm_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// shared sizes and types for the eight slot FM operator bank
// every RTL file refers to these through fm_pkg:: scoped names
// ~~~~~~~~~~~~~~~~~~~~
package fm_pkg;

    localparam int NUM_SLOTS         = 8;
    localparam int SLOT_WIDTH        = 3;
    localparam int PHASE_ACC_WIDTH   = 19;  // 10 phase bits over 9 fraction bits
    localparam int PHASE_WIDTH       = 10;
    localparam int ATTEN_WIDTH       = 9;   // counted in 1/8 steps of the log level
    localparam int WS_WIDTH          = 2;
    localparam int OUT_WIDTH         = 13;
    localparam int LOG_WIDTH         = 12;  // log-sine table word
    localparam int EXP_WIDTH         = 10;  // exponent table word
    localparam int PIPE_DEPTH        = 5;   // param_valid to out_valid in cycles

    // ~~~~~~~~~~~~~~~~~~~~ tables and level
    localparam int TABLE_INDEX_WIDTH = 8;
    localparam int TABLE_SIZE        = 256;
    localparam real PI               = 3.14159265358979;
    localparam int LEVEL_WIDTH       = 13;
    localparam logic [LEVEL_WIDTH-1:0] MUTE_LEVEL = 13'h1000;  // shifts any magnitude to zero
    localparam logic [LEVEL_WIDTH-1:0] LEVEL_MAX  = 13'h1fff;

    // ~~~~~~~~~~~~~~~~~~~~ host field selector
    localparam int FIELD_WIDTH = 2;
    localparam logic [FIELD_WIDTH-1:0] FIELD_PHASE_INC = 2'd0;
    localparam logic [FIELD_WIDTH-1:0] FIELD_WS        = 2'd1;
    localparam logic [FIELD_WIDTH-1:0] FIELD_ATTEN     = 2'd2;
    localparam logic [FIELD_WIDTH-1:0] FIELD_RESTART   = 2'd3;

    typedef logic [SLOT_WIDTH-1:0]         slot_t;
    typedef logic [PHASE_ACC_WIDTH-1:0]    phase_inc_t;  // also the accumulator word
    typedef logic [PHASE_WIDTH-1:0]        phase_t;
    typedef logic [ATTEN_WIDTH-1:0]        atten_t;
    typedef logic [WS_WIDTH-1:0]           waveform_t;
    typedef logic signed [OUT_WIDTH-1:0]   op_out_t;
    typedef logic [LOG_WIDTH-1:0]          log_t;

    typedef enum logic {
        IDLE,  // waiting for a sample tick
        WALK   // reading slots 0 to 7 in turn
    } seq_state_t;

endpackage
